//--- flist.f
source/joy_pkg.sv
source/md_pad_scan.sv
source/neo_pad_scan.sv
source/user_port_joy.sv
source/joy_top.sv
sim/pad_models.sv
sim/tb_joy_top.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_joy_top
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log
PASS  = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q -F "$(PASS)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim/tb_joy_top.sv
`timescale 1ns/1ps

module tb_joy_top;

    localparam int CEN_DIV       = 16;
    localparam int NEO_BITS      = 24;
    localparam int CLK_HALF_NS   = 10;
    localparam int RESET_CLKS    = 8;
    // two full scan rounds with some margin
    localparam int SETTLE_CLKS   = 2200;
    // seven settle waits spread over six tests, each with a round budget
    localparam int WATCHDOG_CLKS = 7 * 2500;

    localparam logic [1:0] MODE_NONE = 2'd0;
    localparam logic [1:0] MODE_MD   = 2'd1;
    localparam logic [1:0] MODE_NEO  = 2'd2;

    logic                clk;
    logic                rst;
    joy_pkg::usb_word_t  usb_joy0;
    joy_pkg::usb_word_t  usb_joy1;
    joy_pkg::usb_word_t  mix_joy0;
    joy_pkg::usb_word_t  mix_joy1;
    joy_pkg::raw_joy_t   raw_joy;
    joy_pkg::user_byte_t user_in;
    joy_pkg::user_byte_t user_out;
    logic [1:0]          pad_mode;
    joy_pkg::pad_word_t  md_pad0;
    joy_pkg::pad_word_t  md_pad1;
    joy_pkg::pad_word_t  neo_pad0;
    joy_pkg::pad_word_t  neo_pad1;

    integer seed;
    int     errors;
    int     tests;
    int     failed_tests;
    int     start_errors;

    joy_top #(
        .CEN_DIV  (CEN_DIV),
        .NEO_BITS (NEO_BITS)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .usb_joy0 (usb_joy0),
        .usb_joy1 (usb_joy1),
        .user_in  (user_in),
        .mix_joy0 (mix_joy0),
        .mix_joy1 (mix_joy1),
        .raw_joy  (raw_joy),
        .user_out (user_out)
    );

    pad_models #(
        .NEO_BITS (NEO_BITS)
    ) pads0 (
        .clk      (clk),
        .mode     (pad_mode),
        .md_joy0  (md_pad0),
        .md_joy1  (md_pad1),
        .neo_joy0 (neo_pad0),
        .neo_joy1 (neo_pad1),
        .user_out (user_out),
        .user_in  (user_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF_NS) clk = ~clk;
    end

    // ==============================
    // expected values and checks
    // ==============================

    // a pad only reaches the low 12 bits of the USB word
    function automatic joy_pkg::usb_word_t mix_expect(input joy_pkg::usb_word_t usb,
                                                      input joy_pkg::pad_word_t pad);
        return usb | {4'b0000, pad};
    endfunction

    function automatic joy_pkg::raw_joy_t raw_expect(input joy_pkg::pad_word_t pad0,
                                                     input joy_pkg::pad_word_t pad1);
        return pad0[5:0] | pad1[5:0];
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_outputs(input joy_pkg::pad_word_t pad0, input joy_pkg::pad_word_t pad1);
        check_value("mix_joy0", mix_joy0, mix_expect(usb_joy0, pad0));
        check_value("mix_joy1", mix_joy1, mix_expect(usb_joy1, pad1));
        check_value("raw_joy", 16'(raw_joy), 16'(raw_expect(pad0, pad1)));
    endtask

    task automatic begin_test();
        start_errors = errors;
    endtask

    task automatic report_test(input string name);
        tests = tests + 1;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    // ==============================
    // stimulus helpers
    // ==============================

    // ends on a falling edge, where the outputs are stable
    task automatic wait_settle();
        repeat (SETTLE_CLKS) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic load_usb_words();
        usb_joy0 = 16'($random(seed));
        usb_joy1 = 16'($random(seed));
    endtask

    task automatic load_md_pads();
        md_pad0 = {4'b0000, 8'($random(seed))};
        md_pad1 = {4'b0000, 8'($random(seed))};
        // right on the second DB9 port is the DB15 data pin, held released
        // so that the DB15 scanner reads an empty chain
        md_pad1[0] = 1'b0;
    endtask

    task automatic load_neo_pads();
        neo_pad0 = 12'($random(seed));
        neo_pad1 = 12'($random(seed));
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        seed         = 32'h7637;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        start_errors = 0;
        rst          = 1'b1;
        usb_joy0     = '0;
        usb_joy1     = '0;
        pad_mode     = MODE_NONE;
        md_pad0      = '0;
        md_pad1      = '0;
        neo_pad0     = '0;
        neo_pad1     = '0;
        repeat (RESET_CLKS) @(posedge clk);
        @(negedge clk);

        begin_test();
        check_outputs('0, '0);
        check_value("user_out", 16'(user_out), 16'h00FF);
        rst = 1'b0;
        report_test("reset values");

        begin_test();
        load_usb_words();
        wait_settle();
        check_outputs('0, '0);
        report_test("no adapter");

        begin_test();
        load_usb_words();
        load_md_pads();
        pad_mode = MODE_MD;
        wait_settle();
        check_outputs(md_pad0, md_pad1);
        check_value("mix_joy0 pad bits 11:8", (mix_joy0 ^ usb_joy0) & 16'h0F00, 16'h0000);
        check_value("mix_joy1 pad bits 11:8", (mix_joy1 ^ usb_joy1) & 16'h0F00, 16'h0000);
        report_test("mega drive pads");

        begin_test();
        load_neo_pads();
        pad_mode = MODE_NEO;
        wait_settle();
        check_outputs(neo_pad0, neo_pad1);
        // with right held on the second DB9 port, pin 5 stays low while split idles high
        // the DB15 scanner then reads an all-pressed chain with its presence bit low,
        // so both adapters count as hooked and the DB15 pads must win
        usb_joy0   = '0;
        usb_joy1   = '0;
        md_pad1[0] = 1'b1;
        pad_mode   = MODE_MD;
        wait_settle();
        check_outputs(12'hFFF, 12'hFFF);
        report_test("neo geo pads");

        begin_test();
        load_md_pads();
        pad_mode = MODE_MD;
        wait_settle();
        check_value("raw_joy", 16'(raw_joy), 16'(raw_expect(md_pad0, md_pad1)));
        load_neo_pads();
        pad_mode = MODE_NEO;
        wait_settle();
        check_value("raw_joy", 16'(raw_joy), 16'(raw_expect(neo_pad0, neo_pad1)));
        report_test("raw summary");

        // the previous test leaves the neo adapter plugged in
        begin_test();
        load_md_pads();
        pad_mode = MODE_MD;
        wait_settle();
        check_outputs(md_pad0, md_pad1);
        report_test("neo geo to mega drive");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // the whole run is bounded by the number of settle waits times a round budget
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- sim/pad_models.sv
`timescale 1ns/1ps

module pad_models #(
    parameter int NEO_BITS = 24
) (
    input  logic                clk,
    input  logic [1:0]          mode,
    input  joy_pkg::pad_word_t  md_joy0,
    input  joy_pkg::pad_word_t  md_joy1,
    input  joy_pkg::pad_word_t  neo_joy0,
    input  joy_pkg::pad_word_t  neo_joy1,
    input  joy_pkg::user_byte_t user_out,
    output joy_pkg::user_byte_t user_in
);

    localparam logic [1:0] MODE_NONE = 2'd0;
    localparam logic [1:0] MODE_MD   = 2'd1;
    localparam logic [1:0] MODE_NEO  = 2'd2;

    // pad word of the DB9 port chosen by the split pin
    joy_pkg::pad_word_t md_word;

    // DB15 chain contents, joy1 MSB first and the presence bit last
    logic [NEO_BITS:0] chain;
    logic              data_pin = 1'b1;
    logic              clk_pin_d = 1'b1;

    // ==============================
    // DB15 serial chain
    // ==============================

    // loadb low keeps reloading the chain from the pad buttons
    // each rising edge of the chain clock puts the next bit on pin 5
    always @(posedge clk) begin
        clk_pin_d <= user_out[1];
        if (!user_out[0]) begin
            chain    <= {~neo_joy1, ~neo_joy0, 1'b0};
            data_pin <= 1'b1;
        end else if (user_out[1] && !clk_pin_d) begin
            data_pin <= chain[NEO_BITS];
            chain    <= {chain[NEO_BITS-1:0], 1'b1};
        end
    end

    // ==============================
    // pin drivers
    // ==============================

    // pin 4 is the port split, pin 0 the DB9 select, every line is active low
    always_comb begin
        user_in = 8'hFF;
        md_word = user_out[4] ? md_joy1 : md_joy0;
        case (mode)
            MODE_MD: begin
                // up and down do not depend on select
                user_in[2] = ~md_word[3];
                user_in[1] = ~md_word[2];
                if (user_out[0]) begin
                    user_in[7] = ~md_word[1];
                    user_in[5] = ~md_word[0];
                    user_in[3] = ~md_word[4];
                    user_in[6] = ~md_word[5];
                end else begin
                    // a three-button pad grounds left and right with select low
                    user_in[7] = 1'b0;
                    user_in[5] = 1'b0;
                    user_in[3] = ~md_word[6];
                    user_in[6] = ~md_word[7];
                end
            end
            MODE_NEO: begin
                user_in[5] = data_pin;
            end
            MODE_NONE: begin
                user_in = 8'hFF;
            end
            default: begin
                user_in = 8'hFF;
            end
        endcase
    end

endmodule

//--- source/joy_top.sv
`timescale 1ns/1ps

module joy_top #(
    parameter int CEN_DIV  = 16,
    parameter int NEO_BITS = 24
) (
    input  logic                clk,
    input  logic                rst,
    input  joy_pkg::usb_word_t  usb_joy0,
    input  joy_pkg::usb_word_t  usb_joy1,
    input  joy_pkg::user_byte_t user_in,
    output joy_pkg::usb_word_t  mix_joy0,
    output joy_pkg::usb_word_t  mix_joy1,
    output joy_pkg::raw_joy_t   raw_joy,
    output joy_pkg::user_byte_t user_out
);

    logic               cen;
    logic               md_scan;
    logic               neo_scan;
    logic [5:0]         md_din;
    logic               neo_din;
    logic               md_hooked;
    logic               neo_hooked;
    logic               md_sample;
    logic               neo_sample;
    joy_pkg::pad_pair_t md_pads;
    joy_pkg::pad_pair_t neo_pads;
    joy_pkg::port_ctl_t md_ctl;
    joy_pkg::port_ctl_t neo_ctl;

    // pin sharing, pacing and the final mix
    user_port_joy #(
        .CEN_DIV    (CEN_DIV)
    ) u_port (
        .clk        (clk),
        .rst        (rst),
        .usb_joy0   (usb_joy0),
        .usb_joy1   (usb_joy1),
        .user_in    (user_in),
        .md_pads    (md_pads),
        .neo_pads   (neo_pads),
        .md_hooked  (md_hooked),
        .neo_hooked (neo_hooked),
        .md_sample  (md_sample),
        .neo_sample (neo_sample),
        .md_ctl     (md_ctl),
        .neo_ctl    (neo_ctl),
        .cen        (cen),
        .md_scan    (md_scan),
        .neo_scan   (neo_scan),
        .md_din     (md_din),
        .neo_din    (neo_din),
        .mix_joy0   (mix_joy0),
        .mix_joy1   (mix_joy1),
        .raw_joy    (raw_joy),
        .user_out   (user_out)
    );

    // two DB9 pads behind the split line
    md_pad_scan u_md (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .scan   (md_scan),
        .din    (md_din),
        .ctl    (md_ctl),
        .pads   (md_pads),
        .hooked (md_hooked),
        .sample (md_sample)
    );

    // serial DB15 chain
    neo_pad_scan #(
        .NEO_BITS (NEO_BITS)
    ) u_neo (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .scan   (neo_scan),
        .din    (neo_din),
        .ctl    (neo_ctl),
        .pads   (neo_pads),
        .hooked (neo_hooked),
        .sample (neo_sample)
    );

endmodule

//--- source/user_port_joy.sv
`timescale 1ns/1ps

module user_port_joy #(
    parameter int CEN_DIV = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  joy_pkg::usb_word_t  usb_joy0,
    input  joy_pkg::usb_word_t  usb_joy1,
    input  joy_pkg::user_byte_t user_in,
    input  joy_pkg::pad_pair_t  md_pads,
    input  joy_pkg::pad_pair_t  neo_pads,
    input  logic                md_hooked,
    input  logic                neo_hooked,
    input  logic                md_sample,
    input  logic                neo_sample,
    input  joy_pkg::port_ctl_t  md_ctl,
    input  joy_pkg::port_ctl_t  neo_ctl,
    output logic                cen,
    output logic                md_scan,
    output logic                neo_scan,
    output logic [5:0]          md_din,
    output logic                neo_din,
    output joy_pkg::usb_word_t  mix_joy0,
    output joy_pkg::usb_word_t  mix_joy1,
    output joy_pkg::raw_joy_t   raw_joy,
    output joy_pkg::user_byte_t user_out
);

    localparam int CNT_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CNT_W-1:0]    cen_cnt;

    // bit 0 gives the turn to the Mega Drive scanner, bit 1 to the Neo Geo one
    logic [1:0]          scan_tok;

    joy_pkg::user_byte_t latch;
    joy_pkg::pad_pair_t  db_pads;
    joy_pkg::port_ctl_t  pins;

    // ==============================
    // phase clock enable
    // ==============================

    // one pulse every CEN_DIV clocks paces both scanners
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            cen     <= 1'b0;
        end else begin
            if (cen_cnt == CNT_W'(CEN_DIV - 1)) begin
                cen_cnt <= '0;
                cen     <= 1'b1;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
                cen     <= 1'b0;
            end
        end
    end

    // the scanners take turns on the shared pins, a finished frame hands over
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_tok <= 2'b01;
        end else if (md_sample || neo_sample) begin
            scan_tok <= {scan_tok[0], scan_tok[1]};
        end
    end

    assign md_scan  = scan_tok[0];
    assign neo_scan = scan_tok[1];

    // ==============================
    // adapter choice and mixing
    // ==============================

    // Neo Geo wins when both adapters claim to be hooked, nothing hooked gives zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            db_pads  <= '0;
            mix_joy0 <= '0;
            mix_joy1 <= '0;
            raw_joy  <= '0;
        end else begin
            if (neo_hooked) begin
                db_pads <= neo_pads;
            end else if (md_hooked) begin
                db_pads <= md_pads;
            end else begin
                db_pads <= '0;
            end
            // pads only fill the low 12 bits of the USB word
            mix_joy0 <= usb_joy0 | joy_pkg::usb_word_t'(db_pads.joy0);
            mix_joy1 <= usb_joy1 | joy_pkg::usb_word_t'(db_pads.joy1);
            raw_joy  <= db_pads.joy0[5:0] | db_pads.joy1[5:0];
        end
    end

    // ==============================
    // user port pins
    // ==============================

    // idle lines of each scanner are high, so an AND merges the two
    assign pins = md_ctl & neo_ctl;

    // pin 0 doubles as DB9 select and DB15 load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            user_out <= 8'hFF;
        end else begin
            user_out <= {3'b111, pins.md_split, 2'b11, pins.joy_clk, pins.md_sel & pins.loadb};
        end
    end

    // input pins are registered once before either scanner looks at them
    always_ff @(posedge clk) begin
        latch <= user_in;
    end

    assign md_din  = {latch[6], latch[3], latch[5], latch[7], latch[1], latch[2]};
    assign neo_din = latch[5];

    // the token can neither get lost nor be shared between the scanners
    a_tok_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(scan_tok));

    a_one_sample: assert property (@(posedge clk) disable iff (rst)
        !(md_sample && neo_sample));

    // a scanner only finishes a frame while it holds the token
    a_sample_owner: assert property (@(posedge clk) disable iff (rst)
        (md_sample |-> md_scan) and (neo_sample |-> neo_scan));

endmodule

//--- source/neo_pad_scan.sv
`timescale 1ns/1ps

module neo_pad_scan #(
    parameter int NEO_BITS = 24
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               scan,
    input  logic               din,
    output joy_pkg::port_ctl_t ctl,
    output joy_pkg::pad_pair_t pads,
    output logic               hooked,
    output logic               sample
);

    // the DB15 chain loads its parallel inputs while loadb is low
    // each rising edge of joy_clk moves the next bit onto din
    // order is joy1 MSB first, then joy0, then the presence bit
    // data and presence are active low on the wire

    localparam int PAD_W = $bits(joy_pkg::pad_word_t);
    localparam int CNT_W = $clog2(NEO_BITS + 1);

    joy_pkg::neo_state_e state;

    // counts clock pairs, NEO_BITS data pairs plus one for presence
    logic [CNT_W-1:0] bit_cnt;

    // the whole chain, presence bit ends up in bit 0
    logic [NEO_BITS:0] shreg;

    logic last_pair;

    assign last_pair = (bit_cnt == CNT_W'(NEO_BITS));

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= joy_pkg::neo_idle;
            bit_cnt <= '0;
            pads    <= '0;
            hooked  <= 1'b0;
            sample  <= 1'b0;
        end else begin
            sample <= 1'b0;
            case (state)
                joy_pkg::neo_idle: begin
                    // wait for the token and the next phase boundary
                    if (cen && scan) begin
                        state <= joy_pkg::neo_load;
                    end
                end
                joy_pkg::neo_load: begin
                    if (cen) begin
                        bit_cnt <= '0;
                        state   <= joy_pkg::neo_clk_lo;
                    end
                end
                joy_pkg::neo_clk_lo: begin
                    if (cen) begin
                        state <= joy_pkg::neo_clk_hi;
                    end
                end
                joy_pkg::neo_clk_hi: begin
                    // the bit for this pair is taken as the high phase ends
                    if (cen) begin
                        if (last_pair) begin
                            state <= joy_pkg::neo_done;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= joy_pkg::neo_clk_lo;
                        end
                    end
                end
                joy_pkg::neo_done: begin
                    // shift register is complete here, publish in one clock
                    pads.joy1 <= ~shreg[2*PAD_W:PAD_W+1];
                    pads.joy0 <= ~shreg[PAD_W:1];
                    hooked    <= ~shreg[0];
                    sample    <= 1'b1;
                    state     <= joy_pkg::neo_idle;
                end
                default: state <= joy_pkg::neo_idle;
            endcase
        end
    end

    // serial data in, no reset because every frame refills it
    always_ff @(posedge clk) begin
        if (cen && state == joy_pkg::neo_clk_hi) begin
            shreg <= {shreg[NEO_BITS-1:0], din};
        end
    end

    // ==============================
    // port control
    // ==============================

    // joy_clk is low during load so the chain never sees a clock edge while loading
    always_comb begin
        ctl.md_split = 1'b1;
        ctl.md_sel   = 1'b1;
        ctl.joy_clk  = 1'b1;
        ctl.loadb    = 1'b1;
        case (state)
            joy_pkg::neo_load: begin
                ctl.loadb   = 1'b0;
                ctl.joy_clk = 1'b0;
            end
            joy_pkg::neo_clk_lo: ctl.joy_clk = 1'b0;
            default: ctl.joy_clk = 1'b1;
        endcase
    end

    // loadb only moves while the chain clock is low, and stays low with it
    a_load_clk: assert property (@(posedge clk) disable iff (rst)
        (!ctl.loadb || $rose(ctl.loadb)) |-> !ctl.joy_clk);

endmodule

//--- source/md_pad_scan.sv
`timescale 1ns/1ps

module md_pad_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               scan,
    input  logic [5:0]         din,
    output joy_pkg::port_ctl_t ctl,
    output joy_pkg::pad_pair_t pads,
    output logic               hooked,
    output logic               sample
);

    // din carries the DB9 lines of the port chosen by md_split, all active low
    // din[0] up, din[1] down, din[2] left, din[3] right
    // din[4] B with select high, A with select low
    // din[5] C with select high, start with select low
    // a three-button pad pulls left and right low while select is low

    joy_pkg::md_state_e state;

    // 0 while the first DB9 port is read, 1 for the second one
    logic port;

    // direction, B and C of the current port from the select-high read
    logic [5:0] hi_bits;

    // first port result, held until the second port is finished
    joy_pkg::pad_word_t joy0_work;
    logic               present0;

    logic [5:0]         din_act;
    logic [5:0]         hi_map;
    joy_pkg::pad_word_t cur_word;
    logic               cur_present;

    // ==============================
    // pin decoding
    // ==============================

    // inverted copy of the pins, so a pressed button reads 1
    assign din_act = ~din;

    // reorder the select-high lines into pad word bits 5:0
    assign hi_map = {din_act[5], din_act[4], din_act[0], din_act[1], din_act[2], din_act[3]};

    // the select-low read adds A and start on top of the stored half
    assign cur_word = {4'b0000, din_act[5], din_act[4], hi_bits};

    // presence check uses the raw pins, both left and right must be low
    assign cur_present = ~din[2] & ~din[3];

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= joy_pkg::md_idle;
            port   <= 1'b0;
            pads   <= '0;
            hooked <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= 1'b0;
            if (cen) begin
                case (state)
                    joy_pkg::md_idle: begin
                        // a frame starts only while this scanner holds the token
                        if (scan) begin
                            port  <= 1'b0;
                            state <= joy_pkg::md_hi_settle;
                        end
                    end
                    joy_pkg::md_hi_settle: state <= joy_pkg::md_hi_read;
                    joy_pkg::md_hi_read:   state <= joy_pkg::md_lo_settle;
                    joy_pkg::md_lo_settle: state <= joy_pkg::md_lo_read;
                    joy_pkg::md_lo_read: begin
                        if (port) begin
                            // both ports are in, publish them together with hooked
                            pads.joy0 <= present0 ? joy0_work : '0;
                            pads.joy1 <= cur_present ? cur_word : '0;
                            hooked    <= present0 | cur_present;
                            sample    <= 1'b1;
                            state     <= joy_pkg::md_idle;
                        end else begin
                            port  <= 1'b1;
                            state <= joy_pkg::md_hi_settle;
                        end
                    end
                    default: state <= joy_pkg::md_idle;
                endcase
            end
        end
    end

    // read data, captured at the end of each read phase
    always_ff @(posedge clk) begin
        if (cen && state == joy_pkg::md_hi_read) begin
            hi_bits <= hi_map;
        end
        if (cen && state == joy_pkg::md_lo_read && !port) begin
            joy0_work <= cur_word;
            present0  <= cur_present;
        end
    end

    // ==============================
    // port control
    // ==============================

    // select is high for the first two phases of a port and low for the last two
    // split stays high between frames so the pins idle at all ones
    always_comb begin
        ctl.md_split = 1'b1;
        ctl.md_sel   = 1'b1;
        ctl.joy_clk  = 1'b1;
        ctl.loadb    = 1'b1;
        case (state)
            joy_pkg::md_hi_settle, joy_pkg::md_hi_read: begin
                ctl.md_split = port;
            end
            joy_pkg::md_lo_settle, joy_pkg::md_lo_read: begin
                ctl.md_split = port;
                ctl.md_sel   = 1'b0;
            end
            default: ctl.md_split = 1'b1;
        endcase
    end

    // the frame always ends in idle, so the next sample is a whole frame away
    a_sample_pulse: assert property (@(posedge clk) disable iff (rst)
        sample |=> !sample);

endmodule

//--- source/joy_pkg.sv
package joy_pkg;

    // ==============================
    // pad and port words
    // ==============================

    // one pad, active high
    // bit 0 right, 1 left, 2 down, 3 up, 4 B, 5 C, 6 A, 7 start
    // bits 8 to 11 are D, select, coin and a reserved bit on DB15 pads, zero on DB9 pads
    typedef logic [11:0] pad_word_t;

    // USB joystick word, the low 12 bits mean the same as in pad_word_t
    typedef logic [15:0] usb_word_t;

    // direction and first two buttons only
    typedef logic [5:0] raw_joy_t;

    // the eight user-port pins
    typedef logic [7:0] user_byte_t;

    // both pads of one adapter, joy1 sits in the upper half
    typedef struct packed {
        pad_word_t joy1;
        pad_word_t joy0;
    } pad_pair_t;

    // pin controls from a scanner, every line idles high
    // the two scanners are ANDed together before the pin map
    typedef struct packed {
        logic md_split;
        logic md_sel;
        logic joy_clk;
        logic loadb;
    } port_ctl_t;

    // ==============================
    // scanner states
    // ==============================

    // Mega Drive frame, four phases per DB9 port
    typedef enum logic [2:0] {
        md_idle,
        md_hi_settle,
        md_hi_read,
        md_lo_settle,
        md_lo_read
    } md_state_e;

    // Neo Geo frame, one load phase then low/high clock pairs
    typedef enum logic [2:0] {
        neo_idle,
        neo_load,
        neo_clk_lo,
        neo_clk_hi,
        neo_done
    } neo_state_e;

endpackage
